//--- logic/wdt_pkg.sv
package wdt_pkg;

  // ------------------------------
  // SFR bus types
  // ------------------------------
  typedef logic [6:0] sfr_addr_t;
  typedef logic [7:0] sfr_byte_t;

  // Watchdog count register
  typedef logic [14:0] wdt_count_t;

  // Reload byte, seen whole on the bus or split into its two fields
  typedef union packed {
    sfr_byte_t raw;
    struct packed {
      logic       presel;
      logic [6:0] reload_hi;
    } fields;
  } wdtrel_u;

  // SFR addresses on the 7-bit bus
  localparam sfr_addr_t PCON_ID   = 7'h07;
  localparam sfr_addr_t IEN0_ID   = 7'h28;
  localparam sfr_addr_t IEN1_ID   = 7'h38;
  localparam sfr_addr_t IP0_ID    = 7'h29;
  localparam sfr_addr_t WDTREL_ID = 7'h06;

  // Watchdog bit in PCON, IEN0, IEN1 and IP0
  localparam int CTL_BIT = 6;

  localparam sfr_byte_t WDTREL_RV = 8'h00;

  // Prescaler sizes
  localparam int         PRES_LENGTH_EXTENSION = 1;
  localparam int         PRES16_WIDTH          = 4;
  localparam logic [3:0] CYCLES_LAST           = 4'd11;

  // Count value that raises the reset request
  localparam wdt_count_t WDT_RSL = 15'h7FFC;

  // Refresh sequence states
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_ARMED = 2'd1;
  localparam logic [1:0] ST_LAST  = 2'd2;

endpackage

//--- logic/sfr_bus_if.sv
`timescale 1ns/1ns

// SFR write port of the core as seen by the watchdog
interface sfr_bus_if;

  // Write strobe, one cycle per write
  logic                 we;
  wdt_pkg::sfr_addr_t   addr;
  wdt_pkg::sfr_byte_t   wdata;

  // One-cycle pulse at each instruction boundary
  logic                 newinstr;

  // Watchdog blocks only listen
  modport sink (
    input we,
    input addr,
    input wdata,
    input newinstr
  );

endinterface

//--- logic/wdt_refresh_fsm.sv
`timescale 1ns/1ns

module wdt_refresh_fsm (
  input  logic      clkper,
  input  logic      resetff,
  sfr_bus_if.sink   bus,
  input  logic      wdt_req,
  output logic      wdt_run,
  output logic      wdt_refresh
);

  logic [1:0] state;
  logic [1:0] state_nxt;
  logic       ien0_wr;
  logic       ien1_set;
  logic       window;

  // IEN0 write of either polarity
  assign ien0_wr  = bus.we && (bus.addr == wdt_pkg::IEN0_ID);
  // IEN1 write with the watchdog bit set
  assign ien1_set = bus.we && (bus.addr == wdt_pkg::IEN1_ID)
                    && bus.wdata[wdt_pkg::CTL_BIT];
  // Refresh allowed in the two states after an arm
  assign window   = (state == wdt_pkg::ST_ARMED) || (state == wdt_pkg::ST_LAST);

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb
  begin
    state_nxt = state;
    if (ien0_wr)
    begin
      // IEN0 write restarts or cancels the sequence
      if (bus.wdata[wdt_pkg::CTL_BIT])
        state_nxt = wdt_pkg::ST_ARMED;
      else
        state_nxt = wdt_pkg::ST_IDLE;
    end
    else if (ien1_set && window)
    begin
      state_nxt = wdt_pkg::ST_IDLE;
    end
    else if (bus.newinstr)
    begin
      // Window closes after the next instruction
      case (state)
        wdt_pkg::ST_ARMED: state_nxt = wdt_pkg::ST_LAST;
        wdt_pkg::ST_LAST:  state_nxt = wdt_pkg::ST_IDLE;
        default:           state_nxt = wdt_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clkper)
  begin
    if (resetff)
      state <= wdt_pkg::ST_IDLE;
    else
      state <= state_nxt;
  end

  // One-cycle refresh after an armed IEN1 write
  always_ff @(posedge clkper)
  begin
    if (resetff)
      wdt_refresh <= 1'b0;
    else
      wdt_refresh <= ien1_set && window;
  end

  // ------------------------------
  // Run latch
  // ------------------------------
  // Start needs no arm, held off while a request is pending
  always_ff @(posedge clkper)
  begin
    if (resetff)
      wdt_run <= 1'b0;
    else if (ien1_set && !wdt_req)
      wdt_run <= 1'b1;
  end

endmodule

//--- logic/wdt_prescaler.sv
`timescale 1ns/1ns

module wdt_prescaler (
  input  logic              clkper,
  input  logic              resetff,
  input  logic              wdt_run,
  input  logic              wdt_refresh,
  input  logic              wdt_tm,
  input  wdt_pkg::wdtrel_u  wdtrel,
  output logic              tick
);

  logic [3:0]                                cycles_reg;
  logic [wdt_pkg::PRES_LENGTH_EXTENSION-1:0] pres_ext;
  logic [wdt_pkg::PRES16_WIDTH-1:0]          pres_16;
  logic                                      cycles_wrap;
  logic                                      ext_wrap;
  logic                                      long_last;

  // Divide-by-12 at its last state
  assign cycles_wrap = (cycles_reg == wdt_pkg::CYCLES_LAST);
  // Short period of 24 clocks ends
  assign ext_wrap    = cycles_wrap && (pres_ext == '1);
  // Long stage only counts when selected
  assign long_last   = !wdtrel.fields.presel || (pres_16 == '1);

  assign tick = wdt_run && ext_wrap && long_last;

  // ------------------------------
  // Divider chain 12, 2, 16
  // ------------------------------
  always_ff @(posedge clkper)
  begin
    if (resetff)
    begin
      cycles_reg <= '0;
      pres_ext   <= '0;
      pres_16    <= '0;
    end
    else if (wdt_run)
    begin
      if (wdt_tm)
      begin
        // Test mode parks every stage at its end
        cycles_reg <= wdt_pkg::CYCLES_LAST;
        pres_ext   <= '1;
        pres_16    <= '1;
      end
      else if (wdt_refresh)
      begin
        // Restart with the counter reload
        cycles_reg <= '0;
        pres_ext   <= '0;
        pres_16    <= '0;
      end
      else
      begin
        if (cycles_wrap)
        begin
          cycles_reg <= '0;
          pres_ext   <= pres_ext + 1'b1;
        end
        else
          cycles_reg <= cycles_reg + 4'd1;
        // Wraps naturally at 15
        if (ext_wrap)
          pres_16 <= pres_16 + 1'b1;
      end
    end
  end

endmodule

//--- logic/wdt_counter.sv
`timescale 1ns/1ns

module wdt_counter (
  input  logic              clkper,
  input  logic              resetff,
  input  logic              wdt_run,
  input  logic              wdt_refresh,
  input  logic              tick,
  input  wdt_pkg::wdtrel_u  wdtrel,
  output logic              wdt_req
);

  wdt_pkg::wdt_count_t count;
  wdt_pkg::wdt_count_t reload_val;
  logic                at_limit;

  // Reload puts the 7-bit field on top and clears the low byte
  assign reload_val = {wdtrel.fields.reload_hi, 8'h00};

  // Count has reached the request value
  assign at_limit = (count == wdt_pkg::WDT_RSL);

  // ------------------------------
  // Count register
  // ------------------------------
  always_ff @(posedge clkper)
  begin
    if (resetff)
      count <= '0;
    else if (wdt_refresh)
      count <= reload_val;
    else if (wdt_run && tick)
      // Rolls over from 7FFF to zero
      count <= count + 15'd1;
  end

  // ------------------------------
  // Reset request
  // ------------------------------
  // Raised one clock after the limit is reached
  // Stays up across the wrap until a refresh
  always_ff @(posedge clkper)
  begin
    if (resetff)
      wdt_req <= 1'b0;
    else if (wdt_refresh)
      wdt_req <= 1'b0;
    else if (wdt_run && at_limit)
      wdt_req <= 1'b1;
  end

endmodule

//--- logic/wdt_sfr_regs.sv
`timescale 1ns/1ns

module wdt_sfr_regs (
  input  logic              clkper,
  input  logic              resetff,
  sfr_bus_if.sink           bus,
  input  logic              wdt_req,
  output wdt_pkg::wdtrel_u  wdtrel,
  output logic              wdt_tm,
  output logic              ip0wdts,
  output logic              wdts
);

  logic wr_wdtrel;
  logic wr_pcon;
  logic wr_ip0;

  // Address decode of the three owned registers
  assign wr_wdtrel = bus.we && (bus.addr == wdt_pkg::WDTREL_ID);
  assign wr_pcon   = bus.we && (bus.addr == wdt_pkg::PCON_ID);
  assign wr_ip0    = bus.we && (bus.addr == wdt_pkg::IP0_ID);

  // ------------------------------
  // WDTREL
  // ------------------------------
  always_ff @(posedge clkper)
  begin
    if (resetff)
      wdtrel.raw <= wdt_pkg::WDTREL_RV;
    else if (wr_wdtrel)
      wdtrel.raw <= bus.wdata;
  end

  // Test mode bit of PCON
  always_ff @(posedge clkper)
  begin
    if (resetff)
      wdt_tm <= 1'b0;
    else if (wr_pcon)
      wdt_tm <= bus.wdata[wdt_pkg::CTL_BIT];
  end

  // ------------------------------
  // Status flag
  // ------------------------------
  // Software write wins over a pending request
  always_ff @(posedge clkper)
  begin
    if (resetff)
      ip0wdts <= 1'b0;
    else if (wr_ip0)
      ip0wdts <= bus.wdata[wdt_pkg::CTL_BIT];
    else if (wdt_req)
      ip0wdts <= 1'b1;
  end

  // Reset request to the system, one register after the counter
  always_ff @(posedge clkper)
  begin
    if (resetff)
      wdts <= 1'b0;
    else
      wdts <= wdt_req;
  end

endmodule

//--- logic/watchdog_top.sv
`timescale 1ns/1ns

module watchdog_top (
  input  logic       clkper,
  input  logic       resetff,
  input  logic       newinstr,
  input  logic       sfrwe,
  input  logic [6:0] sfraddr,
  input  logic [7:0] sfrdatai,
  output logic       wdts,
  output logic       ip0wdts,
  output logic       wdt_tm,
  output logic [7:0] wdtrel
);

  wdt_pkg::wdtrel_u wdtrel_s;
  logic             wdt_run;
  logic             wdt_refresh;
  logic             wdt_req;
  logic             tick;

  // ------------------------------
  // SFR bus bundle
  // ------------------------------
  sfr_bus_if u_bus ();

  assign u_bus.we       = sfrwe;
  assign u_bus.addr     = sfraddr;
  assign u_bus.wdata    = sfrdatai;
  assign u_bus.newinstr = newinstr;

  // Reload byte leaves as a plain byte
  assign wdtrel = wdtrel_s.raw;

  wdt_refresh_fsm u_wdt_refresh_fsm (
    .clkper      (clkper),
    .resetff     (resetff),
    .bus         (u_bus),
    .wdt_req     (wdt_req),
    .wdt_run     (wdt_run),
    .wdt_refresh (wdt_refresh)
  );

  wdt_prescaler u_wdt_prescaler (
    .clkper      (clkper),
    .resetff     (resetff),
    .wdt_run     (wdt_run),
    .wdt_refresh (wdt_refresh),
    .wdt_tm      (wdt_tm),
    .wdtrel      (wdtrel_s),
    .tick        (tick)
  );

  wdt_counter u_wdt_counter (
    .clkper      (clkper),
    .resetff     (resetff),
    .wdt_run     (wdt_run),
    .wdt_refresh (wdt_refresh),
    .tick        (tick),
    .wdtrel      (wdtrel_s),
    .wdt_req     (wdt_req)
  );

  wdt_sfr_regs u_wdt_sfr_regs (
    .clkper      (clkper),
    .resetff     (resetff),
    .bus         (u_bus),
    .wdt_req     (wdt_req),
    .wdtrel      (wdtrel_s),
    .wdt_tm      (wdt_tm),
    .ip0wdts     (ip0wdts),
    .wdts        (wdts)
  );

endmodule

//--- bench/tb_watchdog.sv
`timescale 1ns/1ns

module tb_watchdog;

  // Cycles per test, reset through periodic refresh
  localparam int TEST_CYCLES = 8 + 400 + 2100 + 4300 + 6100 + 96800 + 7200;
  localparam int CYCLE_LIMIT = TEST_CYCLES + TEST_CYCLES / 10;

  // Refresh window as the bench tracks it
  localparam int W_IDLE  = 0;
  localparam int W_ARMED = 1;
  localparam int W_LAST  = 2;

  logic               clkper;
  logic               resetff;
  logic               newinstr;
  logic               sfrwe;
  wdt_pkg::sfr_addr_t sfraddr;
  wdt_pkg::sfr_byte_t sfrdatai;
  logic               wdts;
  logic               ip0wdts;
  logic               wdt_tm;
  wdt_pkg::wdtrel_u   rel_out;

  integer seed   = 71781;
  int     cycle  = 0;
  int     errors = 0;
  int     checks = 0;
  int     tests  = 0;
  int     err_mark;
  string  test_name;

  // ------------------------------
  // Reference model
  // ------------------------------
  wdt_pkg::wdtrel_u m_rel;
  logic             m_tm;
  logic             m_ip0;
  int               m_state;
  // Edge where wdts should rise, from the last accepted refresh
  int               pred_rise;

  watchdog_top u_watchdog_top (
    .clkper   (clkper),
    .resetff  (resetff),
    .newinstr (newinstr),
    .sfrwe    (sfrwe),
    .sfraddr  (sfraddr),
    .sfrdatai (sfrdatai),
    .wdts     (wdts),
    .ip0wdts  (ip0wdts),
    .wdt_tm   (wdt_tm),
    .wdtrel   (rel_out)
  );

  always #50 clkper = ~clkper;

  // Rising edge count, bounded by the run limit
  always @(posedge clkper)
  begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT)
    begin
      $display("Timeout: no result after %0d cycles", cycle);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERROR %s %s: expected %0b, got %0b", test_name, what, exp, act);
    end
  endtask

  task automatic check_rel(input string what, input wdt_pkg::wdtrel_u exp,
                           input wdt_pkg::wdtrel_u act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERROR %s %s: expected %02h, got %02h", test_name, what, exp.raw, act.raw);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = errors;
    tests++;
  endtask

  task automatic end_test();
    $display("test %s: %0d errors", test_name, errors - err_mark);
  endtask

  // Ticks per count step times steps to the limit, plus req and wdts registers
  function automatic int predict_rise(input int e0);
    int period;
    int steps;
    if (m_tm)
      period = 1;
    else if (m_rel.fields.presel)
      period = 384;
    else
      period = 24;
    steps = int'(wdt_pkg::WDT_RSL) - int'(m_rel.fields.reload_hi) * 256;
    return e0 + period * steps + 3;
  endfunction

  // One bus cycle on the falling edge, model follows the same write
  task automatic bus_cycle(input logic we, input wdt_pkg::sfr_addr_t a,
                           input wdt_pkg::sfr_byte_t d, input logic ni);
    logic ien1_set;
    @(negedge clkper);
    sfrwe    = we;
    sfraddr  = a;
    sfrdatai = d;
    newinstr = ni;
    ien1_set = we && (a == wdt_pkg::IEN1_ID) && d[wdt_pkg::CTL_BIT];
    if (we && (a == wdt_pkg::WDTREL_ID))
      m_rel.raw = d;
    if (we && (a == wdt_pkg::PCON_ID))
      m_tm = d[wdt_pkg::CTL_BIT];
    if (we && (a == wdt_pkg::IP0_ID))
      m_ip0 = d[wdt_pkg::CTL_BIT];
    // IEN0 first, then a refresh inside the window, then instruction steps
    if (we && (a == wdt_pkg::IEN0_ID))
      m_state = d[wdt_pkg::CTL_BIT] ? W_ARMED : W_IDLE;
    else if (ien1_set && (m_state != W_IDLE))
    begin
      m_state   = W_IDLE;
      pred_rise = predict_rise(cycle + 1);
    end
    else if (ni)
      m_state = (m_state == W_ARMED) ? W_LAST : W_IDLE;
  endtask

  task automatic idle();
    bus_cycle(1'b0, '0, '0, 1'b0);
  endtask

  task automatic arm_and_refresh();
    bus_cycle(1'b1, wdt_pkg::IEN0_ID, 8'h40, 1'b0);
    bus_cycle(1'b1, wdt_pkg::IEN1_ID, 8'h40, 1'b0);
  endtask

  // wdts low on the edge before, high on the predicted edge
  task automatic expect_rise(input string what, input int at);
    while (cycle < at - 1)
      idle();
    check_flag({what, " before"}, 1'b0, wdts);
    idle();
    check_flag({what, " at"}, 1'b1, wdts);
  endtask

  initial
  begin
    int                 i;
    int                 pick;
    int                 stop;
    int                 next_ref;
    logic               ni;
    logic               seen_high;
    wdt_pkg::sfr_addr_t a;
    wdt_pkg::sfr_byte_t d;
    clkper    = 1'b0;
    resetff   = 1'b1;
    newinstr  = 1'b0;
    sfrwe     = 1'b0;
    sfraddr   = '0;
    sfrdatai  = '0;
    m_rel.raw = wdt_pkg::WDTREL_RV;
    m_tm      = 1'b0;
    m_ip0     = 1'b0;
    m_state   = W_IDLE;
    pred_rise = 0;
    repeat (8) @(negedge clkper);
    resetff = 1'b0;

    begin_test("reset_values");
    check_flag("wdts", 1'b0, wdts);
    check_flag("ip0wdts", 1'b0, ip0wdts);
    check_flag("wdt_tm", 1'b0, wdt_tm);
    check_rel("wdtrel", m_rel, rel_out);
    end_test();

    // ------------------------------
    // Random SFR writes
    // ------------------------------
    begin_test("sfr_random");
    for (i = 0; i < 200; i++)
    begin
      pick = $random(seed) & 7;
      case (pick)
        0:       a = wdt_pkg::PCON_ID;
        1:       a = wdt_pkg::IEN0_ID;
        2:       a = wdt_pkg::IEN1_ID;
        3:       a = wdt_pkg::IP0_ID;
        4:       a = wdt_pkg::WDTREL_ID;
        default: a = 7'($random(seed));
      endcase
      d  = 8'($random(seed));
      ni = 1'($random(seed));
      // Watchdog stays stopped here
      if (a == wdt_pkg::IEN1_ID)
        d[wdt_pkg::CTL_BIT] = 1'b0;
      bus_cycle(1'b1, a, d, ni);
      idle();
      check_rel("wdtrel", m_rel, rel_out);
      check_flag("wdt_tm", m_tm, wdt_tm);
      check_flag("ip0wdts", m_ip0, ip0wdts);
    end
    end_test();

    // Test mode, reload_hi 78..7F
    begin_test("tm_overflow");
    bus_cycle(1'b1, wdt_pkg::IP0_ID, 8'h00, 1'b0);
    bus_cycle(1'b1, wdt_pkg::PCON_ID, 8'h40, 1'b0);
    d = 8'($random(seed)) | 8'h78;
    bus_cycle(1'b1, wdt_pkg::WDTREL_ID, d, 1'b0);
    arm_and_refresh();
    expect_rise("wdts", pred_rise);
    check_flag("ip0wdts with wdts", 1'b1, ip0wdts);
    // Clear write wins for one cycle, pending request sets it again
    bus_cycle(1'b1, wdt_pkg::IP0_ID, 8'h00, 1'b0);
    idle();
    check_flag("ip0wdts cleared", 1'b0, ip0wdts);
    check_flag("wdts held", 1'b1, wdts);
    idle();
    check_flag("ip0wdts set again", 1'b1, ip0wdts);
    end_test();

    // ------------------------------
    // Refresh window
    // ------------------------------
    begin_test("refresh_seq");
    arm_and_refresh();
    repeat (50) idle();
    // IEN1 with no arm
    bus_cycle(1'b1, wdt_pkg::IEN1_ID, 8'h40, 1'b0);
    idle();
    // Window closed by two instruction boundaries
    bus_cycle(1'b1, wdt_pkg::IEN0_ID, 8'h40, 1'b0);
    bus_cycle(1'b0, '0, '0, 1'b1);
    bus_cycle(1'b0, '0, '0, 1'b1);
    bus_cycle(1'b1, wdt_pkg::IEN1_ID, 8'h40, 1'b0);
    expect_rise("older refresh", pred_rise);
    // One boundary in between, still inside
    bus_cycle(1'b1, wdt_pkg::IEN0_ID, 8'h40, 1'b0);
    bus_cycle(1'b0, '0, '0, 1'b1);
    bus_cycle(1'b1, wdt_pkg::IEN1_ID, 8'h40, 1'b0);
    expect_rise("window refresh", pred_rise);
    end_test();

    begin_test("prescale");
    bus_cycle(1'b1, wdt_pkg::PCON_ID, 8'h00, 1'b0);
    bus_cycle(1'b1, wdt_pkg::WDTREL_ID, 8'h7F, 1'b0);
    arm_and_refresh();
    expect_rise("div 24", pred_rise);
    bus_cycle(1'b1, wdt_pkg::WDTREL_ID, 8'hFF, 1'b0);
    arm_and_refresh();
    expect_rise("div 384", pred_rise);
    end_test();

    // Refresh intervals stay below the 2047-cycle overflow
    begin_test("periodic");
    bus_cycle(1'b1, wdt_pkg::WDTREL_ID, 8'h78, 1'b0);
    bus_cycle(1'b1, wdt_pkg::PCON_ID, 8'h40, 1'b0);
    arm_and_refresh();
    repeat (4) idle();
    seen_high = 1'b0;
    stop      = cycle + 5000;
    next_ref  = cycle + 100 + ($random(seed) & 1023);
    while (cycle < stop)
    begin
      if (cycle >= next_ref)
      begin
        arm_and_refresh();
        next_ref = cycle + 100 + ($random(seed) & 1023);
      end
      else
        idle();
      seen_high = seen_high | wdts;
    end
    check_flag("wdts stayed low", 1'b0, seen_high);
    // Last refresh still sets the overflow time
    expect_rise("after last refresh", pred_rise);
    end_test();

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- sim.f
logic/wdt_pkg.sv
logic/sfr_bus_if.sv
logic/wdt_refresh_fsm.sv
logic/wdt_prescaler.sv
logic/wdt_counter.sv
logic/wdt_sfr_regs.sv
logic/watchdog_top.sv
bench/tb_watchdog.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the watchdog testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_watchdog -f sim.f -o tb_watchdog
./obj_dir/tb_watchdog > sim.log 2>&1
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
  exit 0
else
  exit 1
fi
